//--- vlog.f
src/disc_pkg.sv
src/delay_line.sv
src/hysteresis_trigger.sv
src/gate_timer.sv
src/discriminator_channel.sv
src/sample_discriminator.sv
testbench/tb_clock_gen.sv
testbench/sample_discriminator_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, judge the result from the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module sample_discriminator_tb \
  -f vlog.f -Mdir obj_dir -o sim > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "build failed, see build.log"
  cat build.log
  exit 1
fi

./obj_dir/sim > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "Finished with errors" sim.log; then
  echo "simulation FAILED"
  exit 1
fi

if [ $run_status -ne 0 ]; then
  echo "simulator exited with status $run_status"
  exit 1
fi

if ! grep -q "Finished with no errors" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi

echo "simulation passed"
exit 0

//--- testbench/sample_discriminator_tb.sv
// row table, keep window reference model and output monitor for the sample discriminator
`timescale 1ns/1ps

module sample_discriminator_tb;

  import disc_pkg::*;

  localparam int CHANNELS = 2;
  localparam int MAX_DELAY_CYCLES = 16;
  localparam int NUM_ROWS = 9;
  localparam int MAXB = 128;

  typedef struct packed {
    int mode;
    int count;
    int gap;
    int low;
    int high;
    int start;
    int stop;
    int ddel;
    int src0;
    int src1;
    int dis0;
    int dis1;
    int min_kept;
  } row_t;

  typedef struct packed {
    logic [31:0] data;
    int          cycle;
    logic        ts;
    logic [15:0] index;
  } expect_t;

  logic                        adc_clk;
  logic                        arst_n;
  batch_t [CHANNELS-1:0]       data_i;
  logic [CHANNELS-1:0]         valid_i;
  logic [CHANNELS-1:0]         digital_trig_i;
  batch_t [CHANNELS-1:0]       data_o;
  logic [CHANNELS-1:0]         valid_o;
  index_t [CHANNELS-1:0]       ts_o;
  logic [CHANNELS-1:0]         ts_valid_o;
  logic                        reset_state_i;
  logic                        cfg_load_i;
  sample_t [CHANNELS-1:0]      low_thresh_i;
  sample_t [CHANNELS-1:0]      high_thresh_i;
  logic [CHANNELS-1:0][4:0]    start_delay_i;
  logic [CHANNELS-1:0][4:0]    stop_delay_i;
  logic [CHANNELS-1:0][4:0]    digital_delay_i;
  logic [CHANNELS-1:0][1:0]    trig_src_i;
  logic [CHANNELS-1:0]         disable_i;

  int          seed = 32'hfb96_0849;
  int          cycle_count = 0;
  int          error_count = 0;
  int          received [CHANNELS];
  row_t        rows [NUM_ROWS];
  logic [31:0] data_arr [CHANNELS][MAXB];
  bit          dig_arr [CHANNELS][MAXB];
  bit          keep_arr [CHANNELS][MAXB];
  bit          ts_arr [CHANNELS][MAXB];
  expect_t     exp_q [CHANNELS][$];

  tb_clock_gen clock_gen_inst (
    .adc_clk_o (adc_clk),
    .arst_n_o  (arst_n)
  );

  sample_discriminator #(
    .CHANNELS         (CHANNELS),
    .MAX_DELAY_CYCLES (MAX_DELAY_CYCLES)
  ) sample_discriminator_inst (
    .adc_clk         (adc_clk),
    .arst_n_i        (arst_n),
    .data_i          (data_i),
    .valid_i         (valid_i),
    .digital_trig_i  (digital_trig_i),
    .data_o          (data_o),
    .valid_o         (valid_o),
    .ts_o            (ts_o),
    .ts_valid_o      (ts_valid_o),
    .reset_state_i   (reset_state_i),
    .cfg_load_i      (cfg_load_i),
    .low_thresh_i    (low_thresh_i),
    .high_thresh_i   (high_thresh_i),
    .start_delay_i   (start_delay_i),
    .stop_delay_i    (stop_delay_i),
    .digital_delay_i (digital_delay_i),
    .trig_src_i      (trig_src_i),
    .disable_i       (disable_i)
  );

  task automatic stop_on_error(input string msg);
    error_count++;
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1, "run stopped at first error");
  endtask

  ////////////////////////////////////////////////////////////
  // row table
  ////////////////////////////////////////////////////////////
  // mode 0 noise, 1 triangle, 2 pulses, 3 noise with digital triggers
  task automatic load_table();
    //           mode cnt gap  low   high st sp dd s0 s1 d0 d1 min
    rows[0] = '{0, 40, 1,     0,    0, 3, 0, 0, 0, 1, 1, 1, 40};
    rows[1] = '{1, 60, 1, -1000, 2000, 0, 0, 0, 0, 1, 0, 0, 1};
    rows[2] = '{1, 60, 0,   500, 1500, 4, 2, 0, 0, 1, 0, 0, 1};
    rows[3] = '{2, 60, 0,  -300, 3000, 16, 0, 0, 0, 1, 0, 0, 1};
    rows[4] = '{2, 60, 0,  -300, 3000, 0, 16, 0, 0, 1, 0, 0, 1};
    rows[5] = '{2, 70, 0,  -300, 3000, 16, 16, 0, 0, 1, 0, 0, 1};
    rows[6] = '{3, 60, 0,     0,    0, 3, 2, 5, 2, 3, 0, 0, 1};
    rows[7] = '{1, 60, 0, -1000, 2000, 2, 1, 0, 0, 0, 0, 0, 1};
    rows[8] = '{2, 50, 1,  -300, 3000, 0, 3, 0, 0, 1, 0, 1, 1};
  endtask

  function automatic logic [15:0] make_sample(input int mode, input int b, input int i);
    int phase;
    int v;
    phase = b % 32;
    case (mode)
      1: begin
        // triangle from -4000 up to 5600 with light noise
        v = (phase < 16) ? phase * 600 - 4000 : (32 - phase) * 600 - 4000;
        v = v + ($random(seed) & 127) - 64;
      end
      2: begin
        v = ($random(seed) & 1023) - 512;
        if (b % 23 == 5 && i == 1) begin
          v = 8000;
        end
      end
      default: v = $random(seed);
    endcase
    return v[15:0];
  endfunction

  ////////////////////////////////////////////////////////////
  // reference model of the keep window
  ////////////////////////////////////////////////////////////
  task automatic build_model(input int ch, input row_t r, output int kept);
    bit      trig [MAXB];
    bit      lvl;
    bit      any_above;
    bit      all_below;
    bit      keep;
    int      src;
    int      n;
    int      lo;
    int      hi;
    int      w;
    sample_t smp;
    src  = (ch == 0) ? r.src0 : r.src1;
    w    = r.start + r.stop;
    lvl  = 1'b0;
    kept = 0;
    for (int b = 0; b < r.count; b++) begin
      if (src < CHANNELS) begin
        any_above = 1'b0;
        all_below = 1'b1;
        for (int i = 0; i < 2; i++) begin
          smp = sample_t'(data_arr[src][b][16*i +: 16]);
          if (smp > sample_t'(r.high)) begin
            any_above = 1'b1;
          end
          if (smp >= sample_t'(r.low)) begin
            all_below = 1'b0;
          end
        end
        if (any_above) begin
          lvl = 1'b1;
        end else if (all_below) begin
          lvl = 1'b0;
        end
        trig[b] = lvl;
      end else begin
        trig[b] = (b >= r.ddel) ? dig_arr[src-CHANNELS][b-r.ddel] : 1'b0;
      end
    end
    for (int k = 0; k < r.count; k++) begin
      n = k + r.start;
      if (n < r.count) begin
        keep = trig[n];
        lo   = n - w;
        hi   = n - 1;
      end else begin
        // past the last batch the window counter stops stepping
        if (src < CHANNELS) begin
          keep = trig[r.count-1];
        end else begin
          keep = (n - r.ddel < r.count) ? dig_arr[src-CHANNELS][n-r.ddel] : 1'b0;
        end
        lo = r.count - w;
        hi = r.count - 1;
      end
      for (int j = (lo < 0 ? 0 : lo); j <= hi; j++) begin
        keep = keep | trig[j];
      end
      keep_arr[ch][k] = keep;
      ts_arr[ch][k]   = keep && !(k > 0 && keep_arr[ch][k-1]);
      if (keep) begin
        kept++;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // row sequence
  ////////////////////////////////////////////////////////////
  task automatic run_row(input int idx);
    row_t    r;
    int      kept;
    int      timeout;
    int      b;
    int      dis;
    expect_t e;
    r = rows[idx];
    @(posedge adc_clk);
    #0.5;
    for (int ch = 0; ch < CHANNELS; ch++) begin
      low_thresh_i[ch]    = sample_t'(r.low);
      high_thresh_i[ch]   = sample_t'(r.high);
      start_delay_i[ch]   = 5'(r.start);
      stop_delay_i[ch]    = 5'(r.stop);
      digital_delay_i[ch] = 5'(r.ddel);
    end
    trig_src_i[0] = 2'(r.src0);
    trig_src_i[1] = 2'(r.src1);
    disable_i[0]  = r.dis0[0];
    disable_i[1]  = r.dis1[0];
    cfg_load_i    = 1'b1;
    @(posedge adc_clk);
    #0.5 cfg_load_i = 1'b0;
    reset_state_i = 1'b1;
    @(posedge adc_clk);
    #0.5 reset_state_i = 1'b0;
    for (int ch = 0; ch < CHANNELS; ch++) begin
      received[ch] = 0;
      for (int k = 0; k < r.count; k++) begin
        data_arr[ch][k] = {make_sample(r.mode, k, 1), make_sample(r.mode, k, 0)};
        dig_arr[ch][k]  = (r.mode == 3) && (k == 10 || ($random(seed) & 15) == 0);
      end
    end
    for (int ch = 0; ch < CHANNELS; ch++) begin
      dis = (ch == 0) ? r.dis0 : r.dis1;
      build_model(ch, r, kept);
      // a disabled channel forwards every batch
      if (dis != 0) begin
        kept = r.count;
      end
      assert (ch != 0 || kept >= r.min_kept) else begin
        stop_on_error($sformatf("row %0d keeps too few batches in the model", idx));
      end
    end
    b = 0;
    while (b < r.count) begin
      @(posedge adc_clk);
      #0.5;
      if (r.gap != 0 && ($random(seed) & 3) == 0) begin
        // idle cycle leaves the index where it is
        valid_i        = '0;
        data_i         = {$random(seed), $random(seed)};
        digital_trig_i = '0;
      end else begin
        valid_i = '1;
        for (int ch = 0; ch < CHANNELS; ch++) begin
          dis               = (ch == 0) ? r.dis0 : r.dis1;
          data_i[ch]        = data_arr[ch][b];
          digital_trig_i[ch] = dig_arr[ch][b];
          if (dis != 0 || keep_arr[ch][b]) begin
            e.data  = data_arr[ch][b];
            e.cycle = cycle_count + 3 + r.start;
            e.ts    = (dis == 0) && ts_arr[ch][b];
            e.index = 16'(b);
            exp_q[ch].push_back(e);
          end
        end
        b++;
      end
    end
    @(posedge adc_clk);
    #0.5 valid_i = '0;
    digital_trig_i = '0;
    timeout = 0;
    while (exp_q[0].size() > 0 || exp_q[1].size() > 0) begin
      @(posedge adc_clk);
      timeout++;
      if (timeout > 200) begin
        stop_on_error($sformatf("row %0d: expected batches never came out", idx));
      end
    end
    // quiet gap catches stray outputs before the next row
    repeat (24) @(posedge adc_clk);
    $display("row %0d done: %0d and %0d batches out", idx, received[0], received[1]);
  endtask

  ////////////////////////////////////////////////////////////
  // output monitor
  ////////////////////////////////////////////////////////////
  always @(posedge adc_clk) begin
    expect_t e;
    cycle_count = cycle_count + 1;
    for (int ch = 0; ch < CHANNELS; ch++) begin
      if (arst_n && valid_o[ch]) begin
        assert (exp_q[ch].size() > 0) else begin
          stop_on_error($sformatf("channel %0d sent a batch that should be dropped", ch));
        end
        e = exp_q[ch].pop_front();
        received[ch]++;
        assert (data_o[ch] == e.data) else begin
          stop_on_error($sformatf("[FAIL] data_o[%0d]: expected 0x%08h, got 0x%08h",
                                  ch, e.data, data_o[ch]));
        end
        assert (cycle_count == e.cycle) else begin
          stop_on_error($sformatf("channel %0d batch came out at cycle %0d, not %0d",
                                  ch, cycle_count, e.cycle));
        end
        assert (ts_valid_o[ch] == e.ts) else begin
          stop_on_error($sformatf("[FAIL] ts_valid_o[%0d]: expected 0x%0h, got 0x%0h",
                                  ch, e.ts, ts_valid_o[ch]));
        end
        assert (!e.ts || ts_o[ch] == e.index) else begin
          stop_on_error($sformatf("[FAIL] ts_o[%0d]: expected 0x%04h, got 0x%04h",
                                  ch, e.index, ts_o[ch]));
        end
      end else if (arst_n) begin
        assert (!ts_valid_o[ch]) else begin
          stop_on_error($sformatf("channel %0d sent a timestamp without data", ch));
        end
      end
    end
  end

  initial begin
    int timeout;
    data_i          = '0;
    valid_i         = '0;
    digital_trig_i  = '0;
    reset_state_i   = 1'b0;
    cfg_load_i      = 1'b0;
    low_thresh_i    = '0;
    high_thresh_i   = '0;
    start_delay_i   = '0;
    stop_delay_i    = '0;
    digital_delay_i = '0;
    trig_src_i      = '0;
    disable_i       = '0;
    load_table();
    timeout = 0;
    while (arst_n !== 1'b1) begin
      @(posedge adc_clk);
      timeout++;
      if (timeout > 50) begin
        stop_on_error("reset was never released");
      end
    end
    for (int i = 0; i < NUM_ROWS; i++) begin
      run_row(i);
    end
    if (error_count == 0) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      $display("Finished with errors");
      $fatal(1, "checks failed");
    end
  end

endmodule

//--- testbench/tb_clock_gen.sv
// tb_clock_gen: 4 ns adc_clk source and 8-cycle active low reset
`timescale 1ns/1ps

module tb_clock_gen (
  output logic adc_clk_o,
  output logic arst_n_o
);

  initial begin
    adc_clk_o = 1'b0;
    forever begin
      #2 adc_clk_o = ~adc_clk_o;
    end
  end

  // release reset just after an edge
  initial begin
    arst_n_o = 1'b0;
    repeat (8) @(posedge adc_clk_o);
    #0.5 arst_n_o = 1'b1;
  end

endmodule

//--- src/sample_discriminator.sv
// sample_discriminator: top level with per-channel analog triggers and discriminator channels
`timescale 1ns/1ps

module sample_discriminator #(
  parameter int CHANNELS = 2,
  parameter int MAX_DELAY_CYCLES = 16
) (
  input  logic                                                adc_clk,
  input  logic                                                arst_n_i,
  input  disc_pkg::batch_t [CHANNELS-1:0]                     data_i,
  input  logic [CHANNELS-1:0]                                 valid_i,
  input  logic [CHANNELS-1:0]                                 digital_trig_i,
  output disc_pkg::batch_t [CHANNELS-1:0]                     data_o,
  output logic [CHANNELS-1:0]                                 valid_o,
  output disc_pkg::index_t [CHANNELS-1:0]                     ts_o,
  output logic [CHANNELS-1:0]                                 ts_valid_o,
  input  logic                                                reset_state_i,
  input  logic                                                cfg_load_i,
  input  disc_pkg::sample_t [CHANNELS-1:0]                    low_thresh_i,
  input  disc_pkg::sample_t [CHANNELS-1:0]                    high_thresh_i,
  input  logic [CHANNELS-1:0][$clog2(MAX_DELAY_CYCLES+1)-1:0] start_delay_i,
  input  logic [CHANNELS-1:0][$clog2(MAX_DELAY_CYCLES+1)-1:0] stop_delay_i,
  input  logic [CHANNELS-1:0][$clog2(MAX_DELAY_CYCLES+1)-1:0] digital_delay_i,
  input  logic [CHANNELS-1:0][$clog2(2*CHANNELS)-1:0]         trig_src_i,
  input  logic [CHANNELS-1:0]                                 disable_i
);

  import disc_pkg::*;

  // every channel may select any of these
  logic [CHANNELS-1:0] analog_trig;

  for (genvar ch = 0; ch < CHANNELS; ch++) begin : g_channel

    ////////////////////////////////////////////////////////////
    // analog trigger
    ////////////////////////////////////////////////////////////
    sample_t low_thresh_q;
    sample_t high_thresh_q;

    // extreme thresholds after reset, comparator never fires
    always_ff @(posedge adc_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
        low_thresh_q  <= SAMPLE_MIN;
        high_thresh_q <= SAMPLE_MAX;
      end else if (cfg_load_i) begin
        low_thresh_q  <= low_thresh_i[ch];
        high_thresh_q <= high_thresh_i[ch];
      end
    end

    hysteresis_trigger hyst_inst (
      .adc_clk       (adc_clk),
      .arst_n_i      (arst_n_i),
      .clear_i       (reset_state_i),
      .data_i        (data_i[ch]),
      .valid_i       (valid_i[ch]),
      .low_thresh_i  (low_thresh_q),
      .high_thresh_i (high_thresh_q),
      .trig_o        (analog_trig[ch])
    );

    ////////////////////////////////////////////////////////////
    // channel datapath
    ////////////////////////////////////////////////////////////
    discriminator_channel #(
      .CHANNELS         (CHANNELS),
      .MAX_DELAY_CYCLES (MAX_DELAY_CYCLES),
      .CHANNEL_INDEX    (ch)
    ) channel_inst (
      .adc_clk         (adc_clk),
      .arst_n_i        (arst_n_i),
      .reset_state_i   (reset_state_i),
      .cfg_load_i      (cfg_load_i),
      .start_delay_i   (start_delay_i[ch]),
      .stop_delay_i    (stop_delay_i[ch]),
      .digital_delay_i (digital_delay_i[ch]),
      .trig_src_i      (trig_src_i[ch]),
      .disable_i       (disable_i[ch]),
      .data_i          (data_i[ch]),
      .valid_i         (valid_i[ch]),
      .analog_trig_i   (analog_trig),
      .digital_trig_i  (digital_trig_i),
      .data_o          (data_o[ch]),
      .valid_o         (valid_o[ch]),
      .ts_o            (ts_o[ch]),
      .ts_valid_o      (ts_valid_o[ch])
    );

  end

endmodule

//--- src/discriminator_channel.sv
// discriminator_channel: config registers, trigger select, batch index, delay lines, gate, output
`timescale 1ns/1ps

module discriminator_channel #(
  parameter int CHANNELS = 2,
  parameter int MAX_DELAY_CYCLES = 16,
  parameter int CHANNEL_INDEX = 0
) (
  input  logic                                  adc_clk,
  input  logic                                  arst_n_i,
  input  logic                                  reset_state_i,
  input  logic                                  cfg_load_i,
  input  logic [$clog2(MAX_DELAY_CYCLES+1)-1:0] start_delay_i,
  input  logic [$clog2(MAX_DELAY_CYCLES+1)-1:0] stop_delay_i,
  input  logic [$clog2(MAX_DELAY_CYCLES+1)-1:0] digital_delay_i,
  input  logic [$clog2(2*CHANNELS)-1:0]         trig_src_i,
  input  logic                                  disable_i,
  input  disc_pkg::batch_t                      data_i,
  input  logic                                  valid_i,
  input  logic [CHANNELS-1:0]                   analog_trig_i,
  input  logic [CHANNELS-1:0]                   digital_trig_i,
  output disc_pkg::batch_t                      data_o,
  output logic                                  valid_o,
  output disc_pkg::index_t                      ts_o,
  output logic                                  ts_valid_o
);

  import disc_pkg::*;

  localparam int DELAY_WIDTH = $clog2(MAX_DELAY_CYCLES + 1);
  localparam int SRC_WIDTH   = $clog2(2 * CHANNELS);
  localparam int SEL_WIDTH   = (CHANNELS > 1) ? $clog2(CHANNELS) : 1;

  ////////////////////////////////////////////////////////////
  // configuration
  ////////////////////////////////////////////////////////////
  logic [DELAY_WIDTH-1:0] start_delay_q;
  logic [DELAY_WIDTH-1:0] stop_delay_q;
  logic [DELAY_WIDTH-1:0] digital_delay_q;
  logic [SRC_WIDTH-1:0]   trig_src_q;
  logic                   disable_q;

  // comes up disabled, own analog trigger, no delays
  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      start_delay_q   <= '0;
      stop_delay_q    <= '0;
      digital_delay_q <= '0;
      trig_src_q      <= SRC_WIDTH'(CHANNEL_INDEX);
      disable_q       <= 1'b1;
    end else if (cfg_load_i) begin
      start_delay_q   <= start_delay_i;
      stop_delay_q    <= stop_delay_i;
      digital_delay_q <= digital_delay_i;
      trig_src_q      <= trig_src_i;
      disable_q       <= disable_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // batch indexing
  ////////////////////////////////////////////////////////////
  index_t        index_q;
  index_t        index_cur;
  logic          tag_valid_q;
  index_t        tag_index_q;
  batch_t        tag_data_q;
  tagged_batch_t tag_in;
  tagged_batch_t tag_out;

  // a batch arriving with reset_state gets index 0
  assign index_cur = reset_state_i ? '0 : index_q;

  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      index_q     <= '0;
      tag_valid_q <= 1'b0;
    end else begin
      index_q     <= index_cur + index_t'(valid_i);
      tag_valid_q <= valid_i;
    end
  end

  // one stage here lines the batch up with the registered trigger
  always_ff @(posedge adc_clk) begin
    if (valid_i) begin
      tag_index_q <= index_cur;
      tag_data_q  <= data_i;
    end
  end

  assign tag_in = '{valid: tag_valid_q, index: tag_index_q, data: tag_data_q};

  // data waits start_delay cycles so earlier batches can still be kept
  delay_line #(
    .T                (tagged_batch_t),
    .MAX_DELAY_CYCLES (MAX_DELAY_CYCLES)
  ) data_delay_inst (
    .adc_clk  (adc_clk),
    .arst_n_i (arst_n_i),
    .delay_i  (start_delay_q),
    .in_i     (tag_in),
    .out_o    (tag_out)
  );

  ////////////////////////////////////////////////////////////
  // trigger source
  ////////////////////////////////////////////////////////////
  logic [SEL_WIDTH-1:0] analog_sel;
  logic [SEL_WIDTH-1:0] digital_sel;
  logic                 digital_raw;
  logic                 digital_delayed;
  logic                 digital_align_q;
  logic                 trig_sel;

  assign analog_sel  = SEL_WIDTH'(trig_src_q);
  assign digital_sel = SEL_WIDTH'(trig_src_q - SRC_WIDTH'(CHANNELS));
  assign digital_raw = digital_trig_i[digital_sel];

  delay_line #(
    .T                (logic),
    .MAX_DELAY_CYCLES (MAX_DELAY_CYCLES)
  ) trig_delay_inst (
    .adc_clk  (adc_clk),
    .arst_n_i (arst_n_i),
    .delay_i  (digital_delay_q),
    .in_i     (digital_raw),
    .out_o    (digital_delayed)
  );

  // match the one cycle of the registered analog comparator
  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      digital_align_q <= 1'b0;
    end else if (reset_state_i) begin
      digital_align_q <= 1'b0;
    end else begin
      digital_align_q <= digital_delayed;
    end
  end

  assign trig_sel = (int'(trig_src_q) < CHANNELS) ? analog_trig_i[analog_sel] : digital_align_q;

  ////////////////////////////////////////////////////////////
  // gate and output stage
  ////////////////////////////////////////////////////////////
  logic                 keep;
  logic                 run_start;
  logic [DELAY_WIDTH:0] window;

  // trigger keeps start_delay earlier and stop_delay later batches
  assign window = {1'b0, start_delay_q} + {1'b0, stop_delay_q};

  gate_timer #(
    .WINDOW_WIDTH (DELAY_WIDTH + 1)
  ) gate_inst (
    .adc_clk     (adc_clk),
    .arst_n_i    (arst_n_i),
    .clear_i     (reset_state_i),
    .trig_i      (trig_sel),
    .step_i      (tag_valid_q),
    .out_valid_i (tag_out.valid),
    .window_i    (window),
    .keep_o      (keep),
    .run_start_o (run_start)
  );

  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_o    <= 1'b0;
      ts_valid_o <= 1'b0;
    end else begin
      valid_o    <= tag_out.valid && (disable_q || keep);
      ts_valid_o <= tag_out.valid && !disable_q && keep && run_start;
    end
  end

  always_ff @(posedge adc_clk) begin
    data_o <= tag_out.data;
    ts_o   <= tag_out.index;
  end

  // a loaded source must name an existing analog channel or digital input
  trig_src_range_a : assert property (
    @(posedge adc_clk) disable iff (!arst_n_i)
    cfg_load_i |=> int'(trig_src_q) < 2 * CHANNELS
  ) else $error("discriminator_channel: trigger source %0d out of range", trig_src_q);

endmodule

//--- src/gate_timer.sv
// gate_timer: keep window counter and start-of-run marker
`timescale 1ns/1ps

module gate_timer #(
  parameter int WINDOW_WIDTH = 6
) (
  input  logic                    adc_clk,
  input  logic                    arst_n_i,
  input  logic                    clear_i,
  input  logic                    trig_i,
  input  logic                    step_i,
  input  logic                    out_valid_i,
  input  logic [WINDOW_WIDTH-1:0] window_i,
  output logic                    keep_o,
  output logic                    run_start_o
);

  // steps still to keep after the last trigger
  logic [WINDOW_WIDTH-1:0] remain_q;
  // keep decision of the last batch that left the delay line
  logic                    prev_keep_q;

  assign keep_o      = trig_i || (remain_q != '0);
  assign run_start_o = keep_o && !prev_keep_q;

  // window counter, advanced by batches on the trigger side
  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      remain_q <= '0;
    end else if (clear_i) begin
      remain_q <= '0;
    end else if (step_i) begin
      if (trig_i) begin
        remain_q <= window_i;
      end else if (remain_q != '0) begin
        remain_q <= remain_q - 1'b1;
      end
    end
  end

  // run tracking follows the output side, so a trigger seen before
  // the first delayed batch still marks that batch as a run start
  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      prev_keep_q <= 1'b0;
    end else if (clear_i) begin
      prev_keep_q <= 1'b0;
    end else if (out_valid_i) begin
      prev_keep_q <= keep_o;
    end
  end

endmodule

//--- src/hysteresis_trigger.sv
// hysteresis_trigger: per-channel analog comparator with low and high thresholds
`timescale 1ns/1ps

module hysteresis_trigger (
  input  logic              adc_clk,
  input  logic              arst_n_i,
  input  logic              clear_i,
  input  disc_pkg::batch_t  data_i,
  input  logic              valid_i,
  input  disc_pkg::sample_t low_thresh_i,
  input  disc_pkg::sample_t high_thresh_i,
  output logic              trig_o
);

  import disc_pkg::*;

  logic any_above;
  logic all_below;

  // compare every sample of the batch against both thresholds
  always_comb begin
    sample_t sample;
    any_above = 1'b0;
    all_below = 1'b1;
    sample    = '0;
    for (int i = 0; i < PARALLEL_SAMPLES; i++) begin
      sample = data_i[i];
      if (sample > high_thresh_i) begin
        any_above = 1'b1;
      end
      if (!(sample < low_thresh_i)) begin
        all_below = 1'b0;
      end
    end
  end

  // trigger level, only moves on valid batches
  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      trig_o <= 1'b0;
    end else if (clear_i) begin
      trig_o <= 1'b0;
    end else if (valid_i) begin
      if (any_above) begin
        trig_o <= 1'b1;
      end else if (all_below) begin
        trig_o <= 1'b0;
      end
      // between the thresholds the level holds
    end
  end

endmodule

//--- src/delay_line.sv
// delay_line: shift register with a selectable tap for any payload type
`timescale 1ns/1ps

module delay_line #(
  parameter type T = logic,
  parameter int MAX_DELAY_CYCLES = 16
) (
  input  logic                                  adc_clk,
  input  logic                                  arst_n_i,
  input  logic [$clog2(MAX_DELAY_CYCLES+1)-1:0] delay_i,
  input  T                                      in_i,
  output T                                      out_o
);

  // width of an index into the stage array
  localparam int TAP_WIDTH = (MAX_DELAY_CYCLES > 1) ? $clog2(MAX_DELAY_CYCLES) : 1;

  T                     stage_q [MAX_DELAY_CYCLES];
  logic [TAP_WIDTH-1:0] tap_sel;

  // stage 0 holds the input from one cycle ago
  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < MAX_DELAY_CYCLES; i++) begin
        stage_q[i] <= '0;
      end
    end else begin
      stage_q[0] <= in_i;
      for (int i = 1; i < MAX_DELAY_CYCLES; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  // a delay of n reads stage n-1
  assign tap_sel = TAP_WIDTH'(delay_i - 1'b1);

  // zero delay bypasses the register chain
  assign out_o = (delay_i == '0) ? in_i : stage_q[tap_sel];

  // the tap must stay inside the chain
  delay_in_range_a : assert property (
    @(posedge adc_clk) disable iff (!arst_n_i)
    int'(delay_i) <= MAX_DELAY_CYCLES
  ) else $error("delay_line: delay_i %0d beyond %0d stages", delay_i, MAX_DELAY_CYCLES);

endmodule

//--- src/disc_pkg.sv
// sample, batch and index types, tagged batch struct, fixed widths and sample limits
package disc_pkg;

  ////////////////////////////////////////////////////////////
  // fixed widths
  ////////////////////////////////////////////////////////////
  // bits per signed ADC sample
  localparam int SAMPLE_WIDTH = 16;
  // samples delivered per valid cycle
  localparam int PARALLEL_SAMPLES = 2;
  // batch index and timestamp width
  localparam int INDEX_WIDTH = 16;

  ////////////////////////////////////////////////////////////
  // types
  ////////////////////////////////////////////////////////////
  typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;

  // sample 0 sits in the low bits
  typedef logic [PARALLEL_SAMPLES-1:0][SAMPLE_WIDTH-1:0] batch_t;

  // counts valid batches since reset_state, wraps
  typedef logic [INDEX_WIDTH-1:0] index_t;

  // extreme sample values, used as a never-trigger threshold pair
  localparam sample_t SAMPLE_MAX = {1'b0, {(SAMPLE_WIDTH - 1){1'b1}}};
  localparam sample_t SAMPLE_MIN = {1'b1, {(SAMPLE_WIDTH - 1){1'b0}}};

  // batch as it travels through the data delay line
  typedef struct packed {
    logic   valid;
    index_t index;
    batch_t data;
  } tagged_batch_t;

endpackage
